// ==== verilog/ibuf_pkg.sv ====
`default_nettype none

package ibuf_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and limits
    //////////////////////////////////////////////////////////////////////
    localparam int IBUF_AW   = 9;              // 512 QW input buffer
    localparam int PTR_W     = IBUF_AW + 1;    // one extra wrap bit
    localparam int TAG_W     = 5;
    localparam int NUM_TAGS  = 1 << TAG_W;
    localparam int MAX_OS_RQ = 4;
    localparam int LEN_W     = 8;              // up to 128 QWs per request
    localparam int OS_W      = $clog2(MAX_OS_RQ + 1);
    localparam int FQ_W      = $clog2(MAX_OS_RQ) + 1;   // issue fifo ptr, with wrap

    localparam logic [OS_W-1:0] OS_LIMIT = OS_W'(MAX_OS_RQ);

    // tlp header codes
    localparam logic [6:0] FMT_CPLD  = 7'b10_01010;   // cpl with data, 3dw hdr
    localparam logic [2:0] STATUS_SC = 3'b000;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LEN_W-1:0]   qw_len_t;
    typedef logic [PTR_W-1:0]   ptr_t;
    typedef logic [IBUF_AW-1:0] ibuf_addr_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_NEXT,
        RD_SIZE,
        RD_WAIT,
        RD_REQ,
        RD_DONE
    } rd_state_e;

    // max read request size, pcie devctl encoding
    typedef enum logic [2:0] {
        MRRS_128B = 3'd0,
        MRRS_256B = 3'd1,
        MRRS_512B = 3'd2,
        MRRS_1KB  = 3'd3,
        MRRS_2KB  = 3'd4,
        MRRS_4KB  = 3'd5
    } mrrs_e;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [63:0] data;
        logic        sof;
        logic        eof;
        logic        valid;
    } rx_beat_t;

    typedef struct packed {
        logic    valid;
        tag_t    tag;
        ptr_t    addr;     // reserved start in ibuf
        qw_len_t qw;
    } rd_issue_t;

    typedef struct packed {
        logic    valid;
        tag_t    tag;
        qw_len_t qw;       // dword length / 2
    } cpl_hdr_t;

    typedef struct packed {
        logic    valid;
        tag_t    tag;
        qw_len_t qw;
    } cpl_done_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_rel_t;

    // pcie payload is big endian per dword
    function automatic logic [31:0] dw_swap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/rd_req_ctrl.sv ====
`default_nettype none

module rd_req_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ibuf_pkg::mrrs_e         cfg_mrrs,
    input  wire [63:0]                   lbuf_addr,
    input  wire [31:0]                   lbuf_len,
    input  wire                          lbuf_en,
    output logic                         lbuf_dn,
    output logic [63:0]                  hst_addr,
    output logic                         rd,
    output ibuf_pkg::qw_len_t            rd_qw,
    input  wire                          rd_ack,
    input  wire ibuf_pkg::tag_t          rd_tag,
    input  wire                          retired,
    input  wire ibuf_pkg::ptr_t          committed_cons,
    output ibuf_pkg::rd_issue_t          issue
);

    ibuf_pkg::rd_state_e         state;
    logic [31:0]                 qw_left;
    ibuf_pkg::qw_len_t           mx_qw;
    ibuf_pkg::ptr_t              iprod;      // issued producer
    ibuf_pkg::ptr_t              fill;       // ibuf level once this request lands
    logic [ibuf_pkg::OS_W-1:0]   os_cnt;
    logic                        ack;

    assign ack  = rd & rd_ack;
    assign fill = iprod - committed_cons + ibuf_pkg::ptr_t'(rd_qw);

    assign issue = '{valid: ack, tag: rd_tag, addr: iprod, qw: rd_qw};

    // mrrs code to QWs
    always_comb begin
        case (cfg_mrrs)
            ibuf_pkg::MRRS_128B: mx_qw = ibuf_pkg::qw_len_t'(16);
            ibuf_pkg::MRRS_256B: mx_qw = ibuf_pkg::qw_len_t'(32);
            ibuf_pkg::MRRS_512B: mx_qw = ibuf_pkg::qw_len_t'(64);
            default:             mx_qw = ibuf_pkg::qw_len_t'(128);   // capped at 1KB
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // request fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ibuf_pkg::RD_IDLE;
            rd      <= 1'b0;
            lbuf_dn <= 1'b0;
            iprod   <= '0;
            os_cnt  <= '0;
        end else begin
            lbuf_dn <= 1'b0;

            if (ack && !retired) begin
                os_cnt <= os_cnt + 1'b1;
            end else if (!ack && retired) begin
                os_cnt <= os_cnt - 1'b1;
            end

            case (state)
                ibuf_pkg::RD_IDLE: begin
                    hst_addr <= lbuf_addr;
                    qw_left  <= lbuf_len;
                    if (lbuf_en) begin
                        state <= ibuf_pkg::RD_NEXT;
                    end
                end

                ibuf_pkg::RD_NEXT: begin
                    if (qw_left == 32'd0) begin
                        lbuf_dn <= 1'b1;              // whole buffer requested
                        state   <= ibuf_pkg::RD_DONE;
                    end else begin
                        state <= ibuf_pkg::RD_SIZE;
                    end
                end

                ibuf_pkg::RD_SIZE: begin
                    if (qw_left > 32'(mx_qw)) begin
                        rd_qw <= mx_qw;
                    end else begin
                        rd_qw <= qw_left[ibuf_pkg::LEN_W-1:0];   // tail piece
                    end
                    state <= ibuf_pkg::RD_WAIT;
                end

                ibuf_pkg::RD_WAIT: begin
                    // room for all data and a free request slot
                    if (os_cnt < ibuf_pkg::OS_LIMIT && !fill[ibuf_pkg::PTR_W-1]) begin
                        rd    <= 1'b1;
                        state <= ibuf_pkg::RD_REQ;
                    end
                end

                ibuf_pkg::RD_REQ: begin
                    if (rd_ack) begin
                        rd       <= 1'b0;
                        hst_addr <= hst_addr + 64'({rd_qw, 3'b000});
                        qw_left  <= qw_left - 32'(rd_qw);
                        iprod    <= iprod + ibuf_pkg::ptr_t'(rd_qw);
                        state    <= ibuf_pkg::RD_NEXT;
                    end
                end

                ibuf_pkg::RD_DONE: begin
                    if (!lbuf_en) begin
                        state <= ibuf_pkg::RD_IDLE;   // wait for enable to drop
                    end
                end

                default: begin
                    state <= ibuf_pkg::RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpl_filter.sv ====
`default_nettype none

module cpl_filter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire ibuf_pkg::rx_beat_t    rx,
    input  wire ibuf_pkg::rd_issue_t   issue,
    input  wire ibuf_pkg::tag_rel_t    tag_free,
    output ibuf_pkg::cpl_hdr_t         hdr
);

    logic [ibuf_pkg::NUM_TAGS-1:0]  exp_tag;    // one bit per tag in flight
    logic                           hdr_ok;     // sof beat was a good cpld
    logic                           hdr_vld;
    ibuf_pkg::tag_t                 hdr_tag;
    ibuf_pkg::qw_len_t              len_qw;
    ibuf_pkg::qw_len_t              hdr_qw;

    assign hdr = '{valid: hdr_vld, tag: hdr_tag, qw: hdr_qw};

    //////////////////////////////////////////////////////////////////////
    // header decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_tag <= '0;
            hdr_ok  <= 1'b0;
            hdr_vld <= 1'b0;
        end else begin
            hdr_vld <= 1'b0;
            if (issue.valid) begin
                exp_tag[issue.tag] <= 1'b1;
            end
            if (tag_free.valid) begin
                exp_tag[tag_free.tag] <= 1'b0;
            end

            if (rx.valid) begin
                if (rx.sof) begin
                    hdr_ok <= (rx.data[62:56] == ibuf_pkg::FMT_CPLD) &&
                              (rx.data[15:13] == ibuf_pkg::STATUS_SC);
                end else if (hdr_ok) begin
                    hdr_ok  <= 1'b0;
                    hdr_vld <= exp_tag[rx.data[40 +: ibuf_pkg::TAG_W]];   // stray tags dropped
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid && rx.sof) begin
            len_qw <= rx.data[33 +: ibuf_pkg::LEN_W];    // dword length, halved
        end
        hdr_tag <= rx.data[40 +: ibuf_pkg::TAG_W];
        hdr_qw  <= len_qw;
    end

endmodule

`default_nettype wire

// ==== verilog/cpl_writer.sv ====
`default_nettype none

module cpl_writer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire ibuf_pkg::rx_beat_t    rx,
    input  wire ibuf_pkg::cpl_hdr_t    hdr,
    input  wire ibuf_pkg::rd_issue_t   issue,
    output logic                       wr_en,
    output ibuf_pkg::ibuf_addr_t       wr_addr,
    output logic [63:0]                wr_data,
    output ibuf_pkg::cpl_done_t        done
);

    logic [63:0]            beat_data;
    logic                   beat_eof;
    logic                   beat_vld;
    logic                   active;     // inside an accepted completion
    logic                   done_vld;
    ibuf_pkg::tag_t         cur_tag;
    ibuf_pkg::qw_len_t      cur_qw;
    ibuf_pkg::ibuf_addr_t   wptr;
    logic [31:0]            held_dw;    // low dword waiting for its pair
    ibuf_pkg::ibuf_addr_t   tag_ptr [ibuf_pkg::NUM_TAGS];

    assign done = '{valid: done_vld, tag: cur_tag, qw: cur_qw};

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_vld <= 1'b0;
            active   <= 1'b0;
            wr_en    <= 1'b0;
            done_vld <= 1'b0;
        end else begin
            beat_vld <= rx.valid;
            wr_en    <= active & beat_vld;
            done_vld <= active & beat_vld & beat_eof;
            if (hdr.valid) begin
                active <= 1'b1;
            end else if (active && beat_vld && beat_eof) begin
                active <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath and per-tag write pointers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        beat_data <= rx.data;
        beat_eof  <= rx.eof;

        if (issue.valid) begin
            tag_ptr[issue.tag] <= issue.addr[ibuf_pkg::IBUF_AW-1:0];
        end

        if (hdr.valid) begin
            // beat 1 is in the stage now, its low half is payload dw0
            cur_tag <= hdr.tag;
            cur_qw  <= hdr.qw;
            wptr    <= tag_ptr[hdr.tag];
            held_dw <= beat_data[31:0];
        end else if (active && beat_vld) begin
            wr_addr <= wptr;
            wr_data <= {ibuf_pkg::dw_swap(beat_data[63:32]), ibuf_pkg::dw_swap(held_dw)};
            wptr    <= wptr + 1'b1;
            held_dw <= beat_data[31:0];
            if (beat_eof) begin
                tag_ptr[cur_tag] <= wptr + 1'b1;   // next cpl of this tag resumes here
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/commit_tracker.sv ====
`default_nettype none

module commit_tracker (
    input  wire                        clk,
    input  wire                        rst,
    input  wire ibuf_pkg::rd_issue_t   issue,
    input  wire ibuf_pkg::cpl_done_t   done,
    output ibuf_pkg::tag_rel_t         tag_free,
    output logic                       retired,
    output ibuf_pkg::ptr_t             committed_prod
);

    ibuf_pkg::tag_t             fifo [ibuf_pkg::MAX_OS_RQ];   // tags in issue order
    logic [ibuf_pkg::FQ_W-1:0]  wr_ptr;
    logic [ibuf_pkg::FQ_W-1:0]  rd_ptr;
    ibuf_pkg::qw_len_t          req_qw [ibuf_pkg::NUM_TAGS];
    ibuf_pkg::qw_len_t          rcv_qw [ibuf_pkg::NUM_TAGS];
    ibuf_pkg::ptr_t             end_addr [ibuf_pkg::NUM_TAGS];
    ibuf_pkg::tag_t             head;
    ibuf_pkg::tag_t             free_tag;
    logic                       head_ok;

    assign head    = fifo[rd_ptr[ibuf_pkg::FQ_W-2:0]];
    assign head_ok = (wr_ptr != rd_ptr) && (rcv_qw[head] == req_qw[head]);

    assign tag_free = '{valid: retired, tag: free_tag};

    //////////////////////////////////////////////////////////////////////
    // in-order retire
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            retired        <= 1'b0;
            committed_prod <= '0;
        end else begin
            retired <= head_ok;
            if (issue.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_ok) begin
                committed_prod <= end_addr[head];   // oldest request complete
                rd_ptr         <= rd_ptr + 1'b1;
            end
        end
    end

    // per-tag bookkeeping
    always_ff @(posedge clk) begin
        free_tag <= head;
        if (done.valid) begin
            rcv_qw[done.tag] <= rcv_qw[done.tag] + done.qw;
        end
        if (issue.valid) begin
            fifo[wr_ptr[ibuf_pkg::FQ_W-2:0]] <= issue.tag;
            req_qw[issue.tag]   <= issue.qw;
            rcv_qw[issue.tag]   <= '0;
            end_addr[issue.tag] <= issue.addr + ibuf_pkg::ptr_t'(issue.qw);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ibuf_mgmt.sv ====
`default_nettype none

module ibuf_mgmt (
    input  wire                        clk,
    input  wire                        rst,
    input  wire ibuf_pkg::rx_beat_t    rx,
    input  wire ibuf_pkg::mrrs_e       cfg_mrrs,
    input  wire [63:0]                 lbuf_addr,
    input  wire [31:0]                 lbuf_len,     // in QWs
    input  wire                        lbuf_en,
    output logic                       lbuf_dn,
    output logic [63:0]                hst_addr,
    output logic                       rd,
    output ibuf_pkg::qw_len_t          rd_qw,
    input  wire                        rd_ack,
    input  wire ibuf_pkg::tag_t        rd_tag,
    output logic                       wr_en,
    output ibuf_pkg::ibuf_addr_t       wr_addr,
    output logic [63:0]                wr_data,
    output ibuf_pkg::ptr_t             committed_prod,
    input  wire ibuf_pkg::ptr_t        committed_cons
);

    ibuf_pkg::rd_issue_t  issue;      // acked request
    ibuf_pkg::cpl_hdr_t   hdr;        // accepted completion
    ibuf_pkg::cpl_done_t  done;
    ibuf_pkg::tag_rel_t   tag_free;
    logic                 retired;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////
    rd_req_ctrl u_rd_req_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cfg_mrrs       (cfg_mrrs),
        .lbuf_addr      (lbuf_addr),
        .lbuf_len       (lbuf_len),
        .lbuf_en        (lbuf_en),
        .lbuf_dn        (lbuf_dn),
        .hst_addr       (hst_addr),
        .rd             (rd),
        .rd_qw          (rd_qw),
        .rd_ack         (rd_ack),
        .rd_tag         (rd_tag),
        .retired        (retired),
        .committed_cons (committed_cons),
        .issue          (issue)
    );

    //////////////////////////////////////////////////////////////////////
    // completion side
    //////////////////////////////////////////////////////////////////////
    cpl_filter u_cpl_filter (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .issue    (issue),
        .tag_free (tag_free),
        .hdr      (hdr)
    );

    cpl_writer u_cpl_writer (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .hdr     (hdr),
        .issue   (issue),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .done    (done)
    );

    commit_tracker u_commit_tracker (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .done           (done),
        .tag_free       (tag_free),
        .retired        (retired),
        .committed_prod (committed_prod)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ibuf_mgmt.sv ====
`default_nettype none

module tb_ibuf_mgmt;

    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    rst;
    ibuf_pkg::rx_beat_t      rx;
    ibuf_pkg::mrrs_e         cfg_mrrs;
    logic [63:0]             lbuf_addr;
    logic [31:0]             lbuf_len;
    logic                    lbuf_en;
    logic                    lbuf_dn;
    logic [63:0]             hst_addr;
    logic                    rd;
    ibuf_pkg::qw_len_t       rd_qw;
    logic                    rd_ack;
    ibuf_pkg::tag_t          rd_tag;
    logic                    wr_en;
    ibuf_pkg::ibuf_addr_t    wr_addr;
    logic [63:0]             wr_data;
    ibuf_pkg::ptr_t          committed_prod;
    ibuf_pkg::ptr_t          committed_cons;

    ibuf_mgmt uut (.*);

    logic [63:0]             words [0:127];     // case file contents
    int                      cyc;
    int                      limit;
    int                      errors;
    int                      dn_count;
    int                      req_count;
    int                      exp_left;          // QWs not yet requested
    int                      mx;
    int                      idle;
    logic [63:0]             exp_haddr;
    logic                    hold;              // consumer holds committed_cons
    logic                    stall_seen;
    logic                    bad_sts;           // bad status cpl owed to a live tag
    ibuf_pkg::ptr_t          tb_iprod;
    ibuf_pkg::ptr_t          last_prod;
    ibuf_pkg::ptr_t          end_q [$];         // request end pointers, issue order
    ibuf_pkg::tag_t          tag_q [$];
    ibuf_pkg::tag_t          pd_tag [$];        // requests with data still to send
    logic [63:0]             pd_haddr [$];
    int                      pd_left [$];
    ibuf_pkg::ibuf_addr_t    pd_wa [$];
    bit                      exp_vld [512];
    logic [63:0]             exp_data [512];
    bit                      tag_busy [32];
    int                      tag_until [32];

    //////////////////////////////////////////////////////////////////////
    // host memory model and helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] host_dw(input logic [63:0] a);
        return a[31:0] ^ a[63:32] ^ 32'h9e37_79b9;
    endfunction

    // dword as it travels on the link, big endian
    function automatic logic [31:0] wire_dw(input logic [63:0] a);
        logic [31:0] d;
        d = host_dw(a);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    function automatic int size_for_code(input int code);
        case (code)
            0:       return 16;
            1:       return 32;
            2:       return 64;
            default: return 128;
        endcase
    endfunction

    function automatic ibuf_pkg::tag_t pick_tag();
        int t;
        t = $urandom % 32;
        while (tag_busy[t] || cyc < tag_until[t]) begin
            t = (t + 1) % 32;
        end
        return ibuf_pkg::tag_t'(t);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_req(input logic [63:0] got_a, input logic [63:0] exp_a,
                             input ibuf_pkg::qw_len_t got_q, input ibuf_pkg::qw_len_t exp_q);
        if (got_a !== exp_a || got_q !== exp_q) begin
            $display("Mismatch at %0t: request addr %h len %0d, expected addr %h len %0d",
                     $time, got_a, got_q, exp_a, exp_q);
            errors++;
        end
    endtask

    task automatic check_wr(input ibuf_pkg::ibuf_addr_t a, input logic [63:0] got_d,
                            input logic [63:0] exp_d);
        if (got_d !== exp_d) begin
            $display("Mismatch at %0t: ibuf write at %0d data %h, expected %h",
                     $time, a, got_d, exp_d);
            errors++;
        end
    endtask

    task automatic check_prod(input ibuf_pkg::ptr_t got, input ibuf_pkg::ptr_t exp_p);
        if (got !== exp_p) begin
            $display("Mismatch at %0t: committed_prod %h, expected %h", $time, got, exp_p);
            errors++;
        end
    endtask

    // one completion of n QWs, header plus n+1 payload beats
    task automatic send_cpl(input ibuf_pkg::tag_t tag, input logic [63:0] ha,
                            input int n, input logic [2:0] status);
        logic [31:0] dw0;
        logic [31:0] dw1;
        logic [31:0] dw2;
        logic [31:0] hi;
        logic [31:0] lo;
        dw0 = {1'b0, 7'h4a, 14'h0, 10'(2 * n)};
        dw1 = {16'h0100, status, 1'b0, 12'(8 * n)};
        dw2 = {16'h0000, 3'b000, tag, 1'b0, 7'h00};
        for (int b = 0; b < n + 2; b++) begin
            if (b == 0) begin
                hi = dw0;
                lo = dw1;
            end else if (b == 1) begin
                hi = dw2;
                lo = wire_dw(ha);
            end else begin
                hi = wire_dw(ha + 64'(4 * (2 * b - 3)));
                lo = (2 * b - 2 < 2 * n) ? wire_dw(ha + 64'(4 * (2 * b - 2))) : 32'h0;
            end
            rx = '{data: {hi, lo}, sof: (b == 0), eof: (b == n + 1), valid: 1'b1};
            @(posedge clk);
            #1;
        end
        rx = '0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, cycle count and timeout
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        wait (limit > 0);
        while (cyc <= limit) @(posedge clk);
        $display("run stopped: cycle limit of %0d reached", limit);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // host request responder
    //////////////////////////////////////////////////////////////////////
    initial begin
        int             dly;
        int             sz;
        ibuf_pkg::tag_t t;
        ibuf_pkg::ptr_t lvl;
        forever begin
            @(negedge clk);
            if (rd && !rst) begin
                sz  = (exp_left < mx) ? exp_left : mx;
                lvl = tb_iprod - committed_cons + ibuf_pkg::ptr_t'(sz);
                if (lvl >= 10'd512) begin
                    report_error("request issued without room in the input buffer");
                end
                dly = $urandom % 4;
                repeat (dly) @(posedge clk);
                @(posedge clk);
                #1;
                if (exp_left == 0) begin
                    report_error("request issued after the whole buffer was requested");
                end
                check_req(hst_addr, exp_haddr, rd_qw, ibuf_pkg::qw_len_t'(sz));
                t = pick_tag();
                rd_ack = 1'b1;
                rd_tag = t;
                tag_busy[t] = 1'b1;
                end_q.push_back(tb_iprod + ibuf_pkg::ptr_t'(sz));
                tag_q.push_back(t);
                pd_tag.push_back(t);
                pd_haddr.push_back(exp_haddr);
                pd_left.push_back(sz);
                pd_wa.push_back(tb_iprod[8:0]);
                tb_iprod  = tb_iprod + ibuf_pkg::ptr_t'(sz);
                exp_haddr = exp_haddr + 64'(8 * sz);
                exp_left  = exp_left - sz;
                req_count++;
                @(posedge clk);
                #1;
                rd_ack = 1'b0;
            end
        end
    end

    // completions in 16 QW pieces, tags shuffled
    initial begin
        int                   idx;
        int                   n;
        ibuf_pkg::tag_t       t;
        logic [63:0]          ha;
        ibuf_pkg::ibuf_addr_t wa;
        forever begin
            @(posedge clk);
            #1;
            if (bad_sts && pd_tag.size() > 0) begin
                bad_sts = 1'b0;
                send_cpl(pd_tag[0], 64'h100, 4, 3'b001);   // live tag, unsupported request
            end else if (pd_tag.size() > 0 && ($urandom % 3) != 0) begin
                idx = $urandom % pd_tag.size();
                n   = (pd_left[idx] < 16) ? pd_left[idx] : 16;
                t   = pd_tag[idx];
                ha  = pd_haddr[idx];
                wa  = pd_wa[idx];
                pd_haddr[idx] = ha + 64'(8 * n);
                pd_left[idx]  = pd_left[idx] - n;
                pd_wa[idx]    = ibuf_pkg::ibuf_addr_t'(int'(wa) + n);
                if (pd_left[idx] == 0) begin
                    pd_tag.delete(idx);
                    pd_haddr.delete(idx);
                    pd_left.delete(idx);
                    pd_wa.delete(idx);
                end
                for (int j = 0; j < n; j++) begin
                    exp_vld[(int'(wa) + j) % 512]  = 1'b1;
                    exp_data[(int'(wa) + j) % 512] = {host_dw(ha + 64'(8 * j + 4)),
                                                      host_dw(ha + 64'(8 * j))};
                end
                send_cpl(t, ha, n, 3'b000);
            end
        end
    end

    // consumer follows the producer unless held
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (!hold) committed_cons = committed_prod;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output monitors
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (wr_en) begin
                if (!exp_vld[wr_addr]) begin
                    report_error($sformatf("unexpected ibuf write at address %0d", wr_addr));
                end else begin
                    check_wr(wr_addr, wr_data, exp_data[wr_addr]);
                    exp_vld[wr_addr] = 1'b0;
                end
            end
            if (lbuf_dn) dn_count++;
            if (committed_prod != last_prod) begin
                if (end_q.size() == 0) begin
                    report_error("committed_prod moved with no request outstanding");
                end else begin
                    check_prod(committed_prod, end_q.pop_front());
                    tag_busy[tag_q[0]]  = 1'b0;
                    tag_until[tag_q[0]] = cyc + 4;   // filter clears the tag a bit later
                    void'(tag_q.pop_front());
                end
                last_prod = committed_prod;
            end
            if (end_q.size() > ibuf_pkg::MAX_OS_RQ) begin
                report_error("more requests outstanding than the limit");
            end
            // release a held consumer once issuing has stopped
            if (hold) begin
                if (rd || lbuf_dn || end_q.size() > 0 || pd_tag.size() > 0) idle = 0;
                else idle++;
                if (idle >= 40) begin
                    if (tb_iprod - committed_cons + ibuf_pkg::ptr_t'(mx) < 10'd512) begin
                        report_error("requests stalled although the buffer had room");
                    end
                    stall_seen = 1'b1;
                    hold       = 1'b0;
                    $display("space stall at %0t, releasing committed_cons", $time);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // case runner
    //////////////////////////////////////////////////////////////////////
    initial begin
        int n_cases;
        int len;
        int e0;
        int n_fail;
        rst = 1'b1;
        rx = '0;
        cfg_mrrs = ibuf_pkg::MRRS_128B;
        lbuf_addr = '0;
        lbuf_len = '0;
        lbuf_en = 1'b0;
        rd_ack = 1'b0;
        rd_tag = '0;
        committed_cons = '0;
        hold = 1'b0;
        bad_sts = 1'b0;
        cyc = 0;
        limit = 0;
        errors = 0;
        n_fail = 0;
        idle = 0;
        tb_iprod = '0;
        last_prod = '0;
        exp_left = 0;
        mx = 16;
        void'($urandom(75162));
        $readmemh("sim/ibuf_cases.txt", words);
        n_cases = int'(words[0]);
        limit = 1000;
        for (int c = 0; c < n_cases; c++) limit += 64 * int'(words[6 * c + 3]);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int c = 0; c < n_cases; c++) begin
            e0 = errors;
            len = int'(words[6 * c + 3]);
            repeat (4) @(posedge clk);
            #1;
            if (words[6 * c + 4] != 0) begin
                send_cpl(pick_tag(), 64'h0, 4, 3'b000);       // tag nobody asked for
                bad_sts = 1'b1;                               // bad status on a live tag
            end
            committed_cons = committed_prod;
            hold       = (len > 512);
            stall_seen = 1'b0;
            idle       = 0;
            exp_haddr  = words[6 * c + 2];
            exp_left   = len;
            mx         = size_for_code(int'(words[6 * c + 1]));
            req_count  = 0;
            dn_count   = 0;
            cfg_mrrs   = ibuf_pkg::mrrs_e'(words[6 * c + 1][2:0]);
            lbuf_addr  = words[6 * c + 2];
            lbuf_len   = 32'(len);
            lbuf_en    = 1'b1;
            while (dn_count == 0) @(posedge clk);
            #1;
            lbuf_en = 1'b0;
            while (end_q.size() > 0 || pd_tag.size() > 0) @(posedge clk);
            repeat (8) @(posedge clk);
            #1;
            if (req_count != int'(words[6 * c + 5])) begin
                $display("Mismatch at %0t: %0d requests issued, %0d expected",
                         $time, req_count, words[6 * c + 5]);
                errors++;
            end
            if (dn_count != 1) begin
                $display("Mismatch at %0t: lbuf_dn pulsed %0d times, expected 1",
                         $time, dn_count);
                errors++;
            end
            if (exp_left != 0) report_error("buffer not fully requested");
            if (len > 512 && !stall_seen) report_error("no stall on a full buffer");
            check_prod(committed_prod, ibuf_pkg::ptr_t'(words[6 * c + 6]));
            if (errors != e0) n_fail++;
            $display("case %0d: mrrs %0d len %0d reqs %0d: %s", c, words[6 * c + 1], len,
                     req_count, (errors == e0) ? "pass" : "FAIL");
        end
        $display("%0d cases, %0d failed, %0d errors", n_cases, n_fail, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ibuf_cases.txt ====
// first word is the number of cases, then one line per case (hex)
// mrrs  host_addr  len_qw  stray  n_req  final_committed_prod
7
0 0000000100000000 28  0 3 028
1 0000000080001000 64  1 4 08c
2 0000001234567000 c8  0 4 154
3 0000000000200000 12c 0 3 280
5 fffffff000000000 2bc 1 6 13c
0 0000000000000040 11  0 2 14d
1 0000000300000800 40  1 2 18d

// ==== all.f ====
verilog/ibuf_pkg.sv
verilog/rd_req_ctrl.sv
verilog/cpl_filter.sv
verilog/cpl_writer.sv
verilog/commit_tracker.sv
verilog/ibuf_mgmt.sv
sim/tb_ibuf_mgmt.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ibuf_mgmt
FILELIST  = all.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
